//--- verif/cache_patterns.txt
# rw addr wdata exp_word exp_txn exp_wb_addr, hex, rw 0 read 1 write
# exp_wb_addr only counts when exp_txn is 2
# Read miss then hits in set 1
0 00000005 00000000 00000005 1 00000000
0 00000006 00000000 00000006 0 00000000
1 00000006 a5a50006 a5a50006 0 00000000
0 00000006 00000000 a5a50006 0 00000000
0 00000007 00000000 00000007 0 00000000
0 00000004 00000000 00000004 0 00000000
# Write miss in set 2
1 00000009 12340009 12340009 1 00000000
0 00000009 00000000 12340009 0 00000000
0 0000000b 00000000 0000000b 0 00000000
# LRU and write-back in set 5
1 00000034 aaaa0034 aaaa0034 1 00000000
1 00000054 bbbb0054 bbbb0054 1 00000000
1 00000074 cccc0074 cccc0074 1 00000000
1 00000094 dddd0094 dddd0094 1 00000000
1 000000b4 eeee00b4 eeee00b4 2 00000034
0 00000034 00000000 aaaa0034 2 00000054
1 000000d4 ffff00d4 ffff00d4 2 00000074
0 00000054 00000000 bbbb0054 2 00000094
0 00000035 00000000 00000035 0 00000000
0 000000b6 00000000 000000b6 0 00000000

//--- verilog.f
common/cache_geom_pkg.sv
common/cache_ctrl_pkg.sv
controller/way_select.sv
controller/line_update.sv
controller/cache_fsm.sv
logic/tag_data_array.sv
logic/cache_top.sv
verif/cache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module cache_tb -f verilog.f -o cache_sim \
  && ./obj_dir/cache_sim \
  || { echo "simulation failed"; exit 1; }

//--- verif/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                cpu_req_enable;
  logic                cpu_req_rw;
  logic [WORD_W-1:0]   cpu_req_addr;
  logic [WORD_W-1:0]   cpu_req_datain;
  logic                cpu_res_ready;
  logic [WORD_W-1:0]   cpu_res_dataout;
  logic                mem_req_enable;
  logic                mem_req_rw;
  logic [WORD_W-1:0]   mem_req_addr;
  logic [BLOCK_W-1:0]  mem_req_dataout;
  logic                mem_req_ready = 1'b0;
  logic [BLOCK_W-1:0]  mem_req_datain = '0;

  integer      seed = 32'h637b_6171;  // Memory latency draws
  int          mem_wait = 0;          // Cycles left before mem_req_ready
  int          txn_total = 0;         // Memory transfers so far
  int          cycles = 0;
  int          cycle_limit = 0;       // Known once the patterns are loaded
  int          cur_line = 0;          // Pattern line under test
  cache_addr_u blk_addr;
  cache_addr_u wb_addr;               // Last write-back block
  logic [BLOCK_W-1:0] shadow    [logic [WORD_W-1:0]];  // Blocks written back by the cache
  logic [WORD_W-1:0]  ref_words [logic [WORD_W-1:0]];  // Words written by the CPU

  // One entry per pattern line
  int                pat_line  [$];
  logic              pat_rw    [$];
  logic [WORD_W-1:0] pat_addr  [$];
  logic [WORD_W-1:0] pat_wdata [$];
  logic [WORD_W-1:0] pat_exp   [$];
  int                pat_txn   [$];
  cache_addr_u       pat_wb    [$];

  cache_top u_cache_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .cpu_req_enable  (cpu_req_enable),
    .cpu_req_rw      (cpu_req_rw),
    .cpu_req_addr    (cpu_req_addr),
    .cpu_req_datain  (cpu_req_datain),
    .cpu_res_ready   (cpu_res_ready),
    .cpu_res_dataout (cpu_res_dataout),
    .mem_req_enable  (mem_req_enable),
    .mem_req_rw      (mem_req_rw),
    .mem_req_addr    (mem_req_addr),
    .mem_req_dataout (mem_req_dataout),
    .mem_req_ready   (mem_req_ready),
    .mem_req_datain  (mem_req_datain)
  );

  always #50 clk = ~clk;  // 100 ns period

  task automatic report_error(string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(string name, logic [WORD_W-1:0] exp_val, logic [WORD_W-1:0] act_val);
    if (act_val !== exp_val) begin
      report_error($sformatf("FAILED %s: expected %h, actual %h", name, exp_val, act_val));
    end
  endtask

  task automatic check_addr(string name, cache_addr_u exp_val, cache_addr_u act_val);
    if (act_val.word !== exp_val.word) begin
      report_error($sformatf("FAILED %s: expected %h (set %0d), actual %h (set %0d)", name,
                             exp_val.word, exp_val.f.index, act_val.word, act_val.f.index));
    end
  endtask

  task automatic check_count(string name, int exp_val, int act_val);
    if (act_val != exp_val) begin
      report_error($sformatf("FAILED %s: expected %0d, actual %0d", name, exp_val, act_val));
    end
  endtask

  // Unwritten memory holds each word's own address
  function automatic logic [BLOCK_W-1:0] mem_block(logic [WORD_W-1:0] base);
    logic [BLOCK_W-1:0] blk;
    if (shadow.exists(base)) return shadow[base];
    for (int i = 0; i < BLOCK_WORDS; i++) begin
      blk[i*WORD_W +: WORD_W] = base + WORD_W'(i);
    end
    return blk;
  endfunction

  // Word the CPU should see, memory rule unless the CPU wrote it
  function automatic logic [WORD_W-1:0] model_word(logic [WORD_W-1:0] addr);
    if (ref_words.exists(addr)) return ref_words[addr];
    return addr;
  endfunction

  // Memory model with random latency of 1 to 4 cycles
  always @(posedge clk) begin
    mem_req_ready <= 1'b0;
    if (mem_req_enable && !mem_req_ready) begin
      if (mem_wait == 0) begin
        mem_wait = 1 + ($unsigned($random(seed)) % 4);  // New request
      end
      mem_wait = mem_wait - 1;
      if (mem_wait == 0) begin
        blk_addr = mem_req_addr;
        if (blk_addr.f.offset != '0) begin
          report_error($sformatf("memory request to %h is not block aligned", blk_addr.word));
        end
        txn_total = txn_total + 1;
        if (mem_req_rw == OP_WRITE) begin
          wb_addr = blk_addr;
          for (int i = 0; i < BLOCK_WORDS; i++) begin
            check_word($sformatf("line %0d write-back word %0d", cur_line, i),
                       model_word(blk_addr.word + WORD_W'(i)), mem_req_dataout[i*WORD_W +: WORD_W]);
          end
          shadow[blk_addr.word] = mem_req_dataout;
        end else begin
          mem_req_datain <= mem_block(blk_addr.word);  // Valid with the ready pulse
        end
        mem_req_ready <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      report_error($sformatf("simulation timed out after %0d cycles", cycles));
    end
  end

  task automatic load_patterns();
    int                fd;
    int                line_no;
    int                txn_v;
    string             text;
    logic [WORD_W-1:0] rw_v;
    logic [WORD_W-1:0] addr_v;
    logic [WORD_W-1:0] wdata_v;
    logic [WORD_W-1:0] exp_v;
    logic [WORD_W-1:0] wb_v;
    fd = $fopen("verif/cache_patterns.txt", "r");
    if (fd == 0) report_error("cannot open verif/cache_patterns.txt");
    line_no = 0;
    while ($fgets(text, fd) > 0) begin
      line_no++;
      if (text.len() < 2 || text[0] == "#") continue;   // Comment or blank
      if ($sscanf(text, "%h %h %h %h %h %h", rw_v, addr_v, wdata_v, exp_v, txn_v, wb_v) != 6) begin
        report_error($sformatf("pattern line %0d cannot be parsed", line_no));
      end
      pat_line.push_back(line_no);
      pat_rw.push_back(rw_v[0]);
      pat_addr.push_back(addr_v);
      pat_wdata.push_back(wdata_v);
      pat_exp.push_back(exp_v);
      pat_txn.push_back(txn_v);
      pat_wb.push_back(wb_v);
    end
    $fclose(fd);
    if (pat_line.size() == 0) report_error("no patterns found in verif/cache_patterns.txt");
  endtask

  task automatic run_access(int i);
    int edges;
    int txn_start;
    cur_line  = pat_line[i];
    txn_start = txn_total;
    @(posedge clk);
    cpu_req_enable <= 1'b1;
    cpu_req_rw     <= pat_rw[i];
    cpu_req_addr   <= pat_addr[i];
    cpu_req_datain <= pat_wdata[i];
    @(posedge clk);                                      // Accepting edge
    cpu_req_enable <= 1'b0;
    edges = 0;
    @(negedge clk);
    while (!cpu_res_ready) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    @(posedge clk);                                      // Response word registered here
    @(negedge clk);
    if (cpu_res_ready) report_error($sformatf("line %0d cpu_res_ready longer than one cycle",
                                              cur_line));
    check_word($sformatf("line %0d response word", cur_line), pat_exp[i], cpu_res_dataout);
    check_count($sformatf("line %0d memory transfers", cur_line), pat_txn[i],
                txn_total - txn_start);
    if (pat_txn[i] == 0) check_count($sformatf("line %0d hit latency", cur_line), 2, edges);
    if (pat_txn[i] == 2) check_addr($sformatf("line %0d write-back", cur_line), pat_wb[i], wb_addr);
    if (pat_rw[i] == OP_WRITE) ref_words[pat_addr[i]] = pat_wdata[i];
  endtask

  initial begin
    rst_n          = 1'b0;
    cpu_req_enable = 1'b0;
    cpu_req_rw     = OP_READ;
    cpu_req_addr   = '0;
    cpu_req_datain = '0;
    load_patterns();
    cycle_limit = pat_line.size() * 40;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < pat_line.size(); i++) begin
      run_access(i);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                cpu_req_enable,
  input  wire                                cpu_req_rw,
  input  wire [cache_geom_pkg::WORD_W-1:0]   cpu_req_addr,
  input  wire [cache_geom_pkg::WORD_W-1:0]   cpu_req_datain,
  output logic                               cpu_res_ready,
  output logic [cache_geom_pkg::WORD_W-1:0]  cpu_res_dataout,
  output logic                               mem_req_enable,
  output logic                               mem_req_rw,
  output logic [cache_geom_pkg::WORD_W-1:0]  mem_req_addr,
  output logic [cache_geom_pkg::BLOCK_W-1:0] mem_req_dataout,
  input  wire                                mem_req_ready,
  input  wire [cache_geom_pkg::BLOCK_W-1:0]  mem_req_datain
);
  import cache_geom_pkg::*;

  // Controller to array
  logic                          rd_en;
  logic                          wr_en;
  cache_addr_u                   req_addr;      // Registered CPU address
  logic                          req_rw;
  logic [WORD_W-1:0]             req_data;
  logic [BLOCK_W-1:0]            fill_block;    // Block latched from memory

  // Registered ways of the addressed set
  logic [WAYS-1:0]               rd_valid;
  logic [WAYS-1:0]               rd_dirty;
  logic [WAYS-1:0][AGE_W-1:0]    rd_ages;
  logic [WAYS-1:0][TAG_W-1:0]    rd_tags;
  logic [WAYS-1:0][BLOCK_W-1:0]  rd_blocks;

  // Way decision
  logic                          hit;
  logic                          evict;
  logic [WAYS-1:0]               way_sel;
  logic [TAG_W-1:0]              victim_tag;
  logic [BLOCK_W-1:0]            sel_block;
  logic [AGE_W-1:0]              sel_age;
  logic                          sel_dirty;

  // Line going back into the array
  logic [BLOCK_W-1:0]            new_block;
  logic                          new_dirty;
  logic [WAYS-1:0][AGE_W-1:0]    new_ages;

  cache_fsm u_cache_fsm (
    .clk             (clk),
    .rst_n           (rst_n),
    .cpu_req_enable  (cpu_req_enable),
    .cpu_req_rw      (cpu_req_rw),
    .cpu_req_addr    (cpu_req_addr),
    .cpu_req_datain  (cpu_req_datain),
    .cpu_res_ready   (cpu_res_ready),
    .cpu_res_dataout (cpu_res_dataout),
    .mem_req_enable  (mem_req_enable),
    .mem_req_rw      (mem_req_rw),
    .mem_req_addr    (mem_req_addr),
    .mem_req_dataout (mem_req_dataout),
    .mem_req_ready   (mem_req_ready),
    .mem_req_datain  (mem_req_datain),
    .hit             (hit),
    .evict           (evict),
    .victim_tag      (victim_tag),
    .sel_block       (sel_block),
    .new_block       (new_block),
    .req_addr        (req_addr),
    .req_rw          (req_rw),
    .req_data        (req_data),
    .fill_block      (fill_block),
    .rd_en           (rd_en),
    .wr_en           (wr_en)
  );

  way_select u_way_select (
    .req_tag    (req_addr.f.tag),
    .rd_valid   (rd_valid),
    .rd_dirty   (rd_dirty),
    .rd_ages    (rd_ages),
    .rd_tags    (rd_tags),
    .rd_blocks  (rd_blocks),
    .hit        (hit),
    .evict      (evict),
    .way_sel    (way_sel),
    .victim_tag (victim_tag),
    .sel_block  (sel_block),
    .sel_age    (sel_age),
    .sel_dirty  (sel_dirty)
  );

  line_update u_line_update (
    .hit        (hit),
    .req_rw     (req_rw),
    .req_offset (req_addr.f.offset),
    .req_data   (req_data),
    .sel_block  (sel_block),
    .fill_block (fill_block),
    .sel_dirty  (sel_dirty),
    .sel_age    (sel_age),
    .rd_ages    (rd_ages),
    .new_block  (new_block),
    .new_dirty  (new_dirty),
    .new_ages   (new_ages)
  );

  tag_data_array u_tag_data_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en     (rd_en),
    .wr_en     (wr_en),
    .index     (req_addr.f.index),
    .wr_way    (way_sel),           // Hit way, else the victim
    .wr_tag    (req_addr.f.tag),
    .wr_block  (new_block),
    .wr_dirty  (new_dirty),
    .wr_ages   (new_ages),
    .rd_valid  (rd_valid),
    .rd_dirty  (rd_dirty),
    .rd_ages   (rd_ages),
    .rd_tags   (rd_tags),
    .rd_blocks (rd_blocks)
  );

endmodule

`default_nettype wire

//--- logic/tag_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module tag_data_array (
  input  wire                                                           clk,
  input  wire                                                           rst_n,
  input  wire                                                           rd_en,
  input  wire                                                           wr_en,
  input  wire [cache_geom_pkg::INDEX_W-1:0]                             index,
  input  wire [cache_geom_pkg::WAYS-1:0]                                wr_way,
  input  wire [cache_geom_pkg::TAG_W-1:0]                               wr_tag,
  input  wire [cache_geom_pkg::BLOCK_W-1:0]                             wr_block,
  input  wire                                                           wr_dirty,
  input  wire [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::AGE_W-1:0]     wr_ages,
  output logic [cache_geom_pkg::WAYS-1:0]                               rd_valid,
  output logic [cache_geom_pkg::WAYS-1:0]                               rd_dirty,
  output logic [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::AGE_W-1:0]    rd_ages,
  output logic [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::TAG_W-1:0]    rd_tags,
  output logic [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::BLOCK_W-1:0]  rd_blocks
);
  import cache_geom_pkg::*;

  // Line state per set, one bit or field per way
  logic [WAYS-1:0]             valid_mem [SETS];
  logic [WAYS-1:0]             dirty_mem [SETS];
  logic [WAYS-1:0][AGE_W-1:0]  age_mem   [SETS];
  // Payload
  logic [TAG_W-1:0]            tag_mem   [SETS][WAYS];
  logic [BLOCK_W-1:0]          block_mem [SETS][WAYS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SETS; s++) begin
        valid_mem[s] <= '0;                        // All lines invalid
        dirty_mem[s] <= '0;
        for (int w = 0; w < WAYS; w++) begin
          age_mem[s][w] <= AGE_W'(w);              // Way w starts at age w
        end
      end
      rd_valid <= '0;
      rd_dirty <= '0;
      for (int w = 0; w < WAYS; w++) begin
        rd_ages[w] <= AGE_W'(w);
      end
    end else begin
      if (wr_en) begin
        valid_mem[index] <= valid_mem[index] | wr_way;
        dirty_mem[index] <= wr_dirty ? (dirty_mem[index] | wr_way)
                                     : (dirty_mem[index] & ~wr_way);
        age_mem[index]   <= wr_ages;               // Whole set ages at once
      end
      if (rd_en) begin
        rd_valid <= valid_mem[index];
        rd_dirty <= dirty_mem[index];
        rd_ages  <= age_mem[index];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < WAYS; w++) begin
      if (wr_en && wr_way[w]) begin
        tag_mem[index][w]   <= wr_tag;
        block_mem[index][w] <= wr_block;
      end
      if (rd_en) begin
        rd_tags[w]   <= tag_mem[index][w];         // All ways of the set, one cycle later
        rd_blocks[w] <= block_mem[index][w];
      end
    end
  end

  // Exactly one way per array write
  a_wr_way_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> $onehot(wr_way))
    else $error("array write with wr_way %b", wr_way);

endmodule

`default_nettype wire

//--- controller/cache_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cache_fsm (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                cpu_req_enable,
  input  wire                                cpu_req_rw,
  input  wire [cache_geom_pkg::WORD_W-1:0]   cpu_req_addr,
  input  wire [cache_geom_pkg::WORD_W-1:0]   cpu_req_datain,
  output logic                               cpu_res_ready,
  output logic [cache_geom_pkg::WORD_W-1:0]  cpu_res_dataout,
  output logic                               mem_req_enable,
  output logic                               mem_req_rw,
  output logic [cache_geom_pkg::WORD_W-1:0]  mem_req_addr,
  output logic [cache_geom_pkg::BLOCK_W-1:0] mem_req_dataout,
  input  wire                                mem_req_ready,
  input  wire [cache_geom_pkg::BLOCK_W-1:0]  mem_req_datain,
  input  wire                                hit,
  input  wire                                evict,
  input  wire [cache_geom_pkg::TAG_W-1:0]    victim_tag,
  input  wire [cache_geom_pkg::BLOCK_W-1:0]  sel_block,
  input  wire [cache_geom_pkg::BLOCK_W-1:0]  new_block,
  output cache_geom_pkg::cache_addr_u        req_addr,
  output logic                               req_rw,
  output logic [cache_geom_pkg::WORD_W-1:0]  req_data,
  output logic [cache_geom_pkg::BLOCK_W-1:0] fill_block,
  output logic                               rd_en,
  output logic                               wr_en
);
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;

  logic [2:0]   state;
  logic [2:0]   state_nxt;
  logic         mem_done;      // Memory answered an active request
  cache_addr_u  mem_addr;

  assign mem_done = mem_req_enable & mem_req_ready;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:     if (cpu_req_enable) state_nxt = ST_LOOKUP;
      ST_LOOKUP:   state_nxt = ST_COMPARE;              // Ways come back from the array
      ST_COMPARE: begin
        if (hit)        state_nxt = ST_UPDATE;
        else if (evict) state_nxt = ST_EVICT;           // Dirty victim first
        else            state_nxt = ST_ALLOCATE;
      end
      ST_EVICT:    if (mem_done) state_nxt = ST_ALLOCATE;
      ST_ALLOCATE: if (mem_done) state_nxt = ST_UPDATE;
      ST_UPDATE:   state_nxt = ST_IDLE;
      default:     state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= ST_IDLE;
      mem_req_enable <= 1'b0;
    end else begin
      state <= state_nxt;
      // Enable drops the cycle after ready, so a fill after a write-back
      // starts one idle cycle late
      case (state)
        ST_COMPARE:            mem_req_enable <= ~hit;
        ST_EVICT, ST_ALLOCATE: mem_req_enable <= ~mem_done;
        default:               mem_req_enable <= 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && cpu_req_enable) begin
      req_addr <= cpu_req_addr;                         // Request held for the whole access
      req_rw   <= cpu_req_rw;
      req_data <= cpu_req_datain;
    end
    if (state == ST_COMPARE && evict) begin
      mem_req_dataout <= sel_block;                     // Victim block, stable for write-back
    end
    if (state == ST_ALLOCATE && mem_done) begin
      fill_block <= mem_req_datain;
    end
    if (state == ST_UPDATE) begin
      cpu_res_dataout <= new_block[req_addr.f.offset * WORD_W +: WORD_W];
    end
  end

  // Block address, victim tag on write-back
  always_comb begin
    mem_addr          = req_addr;
    mem_addr.f.offset = '0;
    if (state == ST_EVICT) begin
      mem_addr.f.tag = victim_tag;
    end
  end

  assign mem_req_addr  = mem_addr.word;
  assign mem_req_rw    = (state == ST_EVICT) ? OP_WRITE : OP_READ;
  assign rd_en         = (state == ST_LOOKUP);
  assign wr_en         = (state == ST_UPDATE);          // Array write on the edge ending UPDATE
  assign cpu_res_ready = (state == ST_UPDATE);

  // Memory is only driven while a transfer is pending
  a_mem_en_state: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_enable |-> (state == ST_EVICT || state == ST_ALLOCATE))
    else $error("mem_req_enable in state %0d", state);

  // CPU must wait for cpu_res_ready before the next request
  a_req_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_req_enable |-> state == ST_IDLE)
    else $error("cpu_req_enable while busy in state %0d", state);

endmodule

`default_nettype wire

//--- controller/line_update.sv
`timescale 1ns/1ps
`default_nettype none

module line_update (
  input  wire                                                           hit,
  input  wire                                                           req_rw,
  input  wire [cache_geom_pkg::OFFSET_W-1:0]                            req_offset,
  input  wire [cache_geom_pkg::WORD_W-1:0]                              req_data,
  input  wire [cache_geom_pkg::BLOCK_W-1:0]                             sel_block,
  input  wire [cache_geom_pkg::BLOCK_W-1:0]                             fill_block,
  input  wire                                                           sel_dirty,
  input  wire [cache_geom_pkg::AGE_W-1:0]                               sel_age,
  input  wire [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::AGE_W-1:0]     rd_ages,
  output logic [cache_geom_pkg::BLOCK_W-1:0]                            new_block,
  output logic                                                          new_dirty,
  output logic [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::AGE_W-1:0]    new_ages
);
  import cache_geom_pkg::*;
  import cache_ctrl_pkg::*;

  // Hit block or fresh fill, request word merged on writes
  always_comb begin
    new_block = hit ? sel_block : fill_block;
    if (req_rw == OP_WRITE) begin
      new_block[req_offset * WORD_W +: WORD_W] = req_data;
    end
  end

  always_comb begin
    if (req_rw == OP_WRITE) new_dirty = 1'b1;
    else if (hit)           new_dirty = sel_dirty;     // Read hit keeps the line as it was
    else                    new_dirty = 1'b0;          // Clean copy from memory
  end

  // Ages stay a permutation, so the selected way is the one holding sel_age
  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      if (rd_ages[w] == sel_age)     new_ages[w] = '0;
      else if (rd_ages[w] < sel_age) new_ages[w] = rd_ages[w] + 1'b1;
      else                           new_ages[w] = rd_ages[w];  // Older ways untouched
    end
  end

endmodule

`default_nettype wire

//--- controller/way_select.sv
`timescale 1ns/1ps
`default_nettype none

module way_select (
  input  wire [cache_geom_pkg::TAG_W-1:0]                               req_tag,
  input  wire [cache_geom_pkg::WAYS-1:0]                                rd_valid,
  input  wire [cache_geom_pkg::WAYS-1:0]                                rd_dirty,
  input  wire [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::AGE_W-1:0]     rd_ages,
  input  wire [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::TAG_W-1:0]     rd_tags,
  input  wire [cache_geom_pkg::WAYS-1:0][cache_geom_pkg::BLOCK_W-1:0]   rd_blocks,
  output logic                                                          hit,
  output logic                                                          evict,
  output logic [cache_geom_pkg::WAYS-1:0]                               way_sel,
  output logic [cache_geom_pkg::TAG_W-1:0]                              victim_tag,
  output logic [cache_geom_pkg::BLOCK_W-1:0]                            sel_block,
  output logic [cache_geom_pkg::AGE_W-1:0]                              sel_age,
  output logic                                                          sel_dirty
);
  import cache_geom_pkg::*;

  logic [WAYS-1:0] hit_way;
  logic [WAYS-1:0] victim_way;   // Oldest way, one-hot while ages are a permutation
  logic [WAYS-1:0] age_seen;

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      hit_way[w]    = rd_valid[w] && (rd_tags[w] == req_tag);
      victim_way[w] = (rd_ages[w] == AGE_W'(WAYS - 1));
    end
  end

  assign hit     = |hit_way;
  assign way_sel = hit ? hit_way : victim_way;
  // Write-back only for a valid dirty victim
  assign evict   = !hit && |(victim_way & rd_valid & rd_dirty);

  // One-hot muxes over the ways
  always_comb begin
    victim_tag = '0;
    sel_block  = '0;
    sel_age    = '0;
    sel_dirty  = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      if (victim_way[w]) victim_tag = rd_tags[w];
      if (way_sel[w]) begin
        sel_block = rd_blocks[w];
        sel_age   = rd_ages[w];
        sel_dirty = rd_dirty[w];
      end
    end
  end

  // Checked once the set holds real lines
  always_comb begin
    age_seen = '0;
    for (int w = 0; w < WAYS; w++) begin
      age_seen[rd_ages[w]] = 1'b1;
    end
    if (|rd_valid) begin
      a_hit_onehot: assert ($onehot0(hit_way))
        else $error("tag %h hits in ways %b", req_tag, hit_way);
      a_ages_perm: assert (&age_seen)   // Every age used once
        else $error("ages not distinct %p", rd_ages);
    end
  end

endmodule

`default_nettype wire

//--- common/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

  // Controller states
  localparam logic [2:0] ST_IDLE     = 3'd0;  // Waits for a CPU request
  localparam logic [2:0] ST_LOOKUP   = 3'd1;  // Array read of the indexed set
  localparam logic [2:0] ST_COMPARE  = 3'd2;  // Tag compare on the registered ways
  localparam logic [2:0] ST_EVICT    = 3'd3;  // Dirty victim goes back to memory
  localparam logic [2:0] ST_ALLOCATE = 3'd4;  // Block fill from memory
  localparam logic [2:0] ST_UPDATE   = 3'd5;  // Array write and CPU response

  // Request opcodes, CPU and memory side alike
  localparam logic OP_READ  = 1'b0;
  localparam logic OP_WRITE = 1'b1;

endpackage

`default_nettype wire

//--- common/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

  localparam int WORD_W      = 32;                       // CPU word, also the word address width
  localparam int BLOCK_WORDS = 4;                        // Words per block
  localparam int OFFSET_W    = $clog2(BLOCK_WORDS);      // Word offset inside a block
  localparam int SETS        = 8;
  localparam int INDEX_W     = $clog2(SETS);
  localparam int TAG_W       = WORD_W - INDEX_W - OFFSET_W;
  localparam int WAYS        = 4;                        // Associativity
  localparam int AGE_W       = $clog2(WAYS);             // Age 0 is newest, WAYS-1 is the victim
  localparam int BLOCK_W     = BLOCK_WORDS * WORD_W;

  // One word address seen either raw or split into its cache fields
  typedef union packed {
    logic [WORD_W-1:0] word;
    struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;                       // Word select, zero on memory requests
    } f;
  } cache_addr_u;

endpackage

`default_nettype wire
